/* source/mips_settings.svh */
`ifndef MIPS_SETTINGS_SVH
`define MIPS_SETTINGS_SVH

// First fetch address after reset, in the boot ROM segment
`define RESET_VECTOR 32'hBFC00000

// Fetching from this address stops the core until the next reset
`define HALT_ADDRESS 32'h00000000

// jal writes its return address here
`define LINK_REG 5'd31

// Result register, exported at the top level for the testbench
`define V0_REG 5'd2

// Offset from the current pc to the return address, past the delay slot
`define LINK_OFFSET 32'd8

`endif

/* source/mips_pkg.sv */
package mips_pkg;

  // Primary opcodes, bits 31:26 of the instruction
  typedef enum logic [5:0] {
    OP_RTYPE = 6'h00,
    OP_J     = 6'h02,
    OP_JAL   = 6'h03,
    OP_BEQ   = 6'h04,
    OP_BNE   = 6'h05,
    OP_ADDIU = 6'h09,
    OP_SLTI  = 6'h0A,
    OP_ANDI  = 6'h0C,
    OP_ORI   = 6'h0D,
    OP_XORI  = 6'h0E,
    OP_LUI   = 6'h0F,
    OP_LB    = 6'h20,
    OP_LH    = 6'h21,
    OP_LW    = 6'h23,
    OP_LBU   = 6'h24,
    OP_LHU   = 6'h25,
    OP_SW    = 6'h2B
  } opcode_e;

  // Function field of R-type instructions, bits 5:0
  typedef enum logic [5:0] {
    FN_SLL  = 6'h00,
    FN_SRL  = 6'h02,
    FN_SRA  = 6'h03,
    FN_JR   = 6'h08,
    FN_JALR = 6'h09,
    FN_ADDU = 6'h21,
    FN_SUBU = 6'h23,
    FN_AND  = 6'h24,
    FN_OR   = 6'h25,
    FN_XOR  = 6'h26,
    FN_SLT  = 6'h2A,
    FN_SLTU = 6'h2B
  } funct_e;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT,
    ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
  } alu_op_e;

  typedef enum logic [1:0] {DST_RT, DST_RD, DST_LINK} reg_dst_e;
  typedef enum logic [1:0] {WB_ALU, WB_LOAD, WB_LINK} wb_sel_e;
  typedef enum logic [2:0] {LD_WORD, LD_BYTE, LD_BYTE_U, LD_HALF, LD_HALF_U} load_kind_e;
  typedef enum logic [1:0] {BR_NONE, BR_BEQ, BR_BNE} branch_e;
  typedef enum logic [1:0] {JMP_NONE, JMP_IMM, JMP_REG} jump_e;

  // Everything the datapath needs to run one instruction
  typedef struct packed {
    alu_op_e    alu_op;
    logic       alu_src_imm;    // Operand B is the extended immediate
    logic       imm_zero_ext;   // Logical immediates are zero-extended
    logic       shift_by_shamt; // ALU shift amount comes from bits 10:6
    reg_dst_e   reg_dst;
    wb_sel_e    wb_sel;
    logic       reg_write;
    logic       mem_write;
    load_kind_e load_kind;
    branch_e    branch;
    jump_e      jump;
  } ctrl_t;

endpackage

/* source/control_decoder.sv */
module control_decoder import mips_pkg::*; (
  input  logic [31:0] instr,
  output ctrl_t       ctrl
);

  opcode_e opcode;
  funct_e  funct;

  assign opcode = opcode_e'(instr[31:26]);
  assign funct  = funct_e'(instr[5:0]);

  always_comb begin
    // Safe default is a no-op, so any encoding not listed below writes nothing
    ctrl = '{alu_op: ALU_ADD, alu_src_imm: 1'b0, imm_zero_ext: 1'b0,
             shift_by_shamt: 1'b0, reg_dst: DST_RT, wb_sel: WB_ALU,
             reg_write: 1'b0, mem_write: 1'b0, load_kind: LD_WORD,
             branch: BR_NONE, jump: JMP_NONE};
    case (opcode)
      OP_RTYPE: begin
        ctrl.reg_dst   = DST_RD;
        ctrl.reg_write = 1'b1; // Cleared again for jr and for unknown functions
        case (funct)
          FN_ADDU: ctrl.alu_op = ALU_ADD;
          FN_SUBU: ctrl.alu_op = ALU_SUB;
          FN_AND:  ctrl.alu_op = ALU_AND;
          FN_OR:   ctrl.alu_op = ALU_OR;
          FN_XOR:  ctrl.alu_op = ALU_XOR;
          FN_SLT:  ctrl.alu_op = ALU_SLT;
          FN_SLTU: ctrl.alu_op = ALU_SLTU;
          FN_SLL, FN_SRL, FN_SRA: begin
            // Shifts act on rt with the constant amount from the shamt field
            ctrl.alu_op         = (funct == FN_SLL) ? ALU_SLL :
                                  (funct == FN_SRL) ? ALU_SRL : ALU_SRA;
            ctrl.shift_by_shamt = 1'b1;
          end
          FN_JR: begin
            ctrl.jump      = JMP_REG; // Target is rs, nothing is written
            ctrl.reg_write = 1'b0;
          end
          FN_JALR: begin
            ctrl.jump   = JMP_REG;
            ctrl.wb_sel = WB_LINK; // rd receives pc + 8
          end
          default: ctrl.reg_write = 1'b0;
        endcase
      end
      OP_J:   ctrl.jump = JMP_IMM;
      OP_JAL: begin
        ctrl.jump      = JMP_IMM;
        ctrl.reg_dst   = DST_LINK;
        ctrl.wb_sel    = WB_LINK;
        ctrl.reg_write = 1'b1;
      end
      OP_BEQ: begin
        ctrl.alu_op = ALU_SUB; // Zero flag decides
        ctrl.branch = BR_BEQ;
      end
      OP_BNE: begin
        ctrl.alu_op = ALU_SUB;
        ctrl.branch = BR_BNE;
      end
      OP_ADDIU, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
        ctrl.alu_src_imm  = 1'b1;
        ctrl.reg_write    = 1'b1;
        ctrl.imm_zero_ext = opcode inside {OP_ANDI, OP_ORI, OP_XORI};
        ctrl.alu_op       = (opcode == OP_SLTI) ? ALU_SLT :
                            (opcode == OP_ANDI) ? ALU_AND :
                            (opcode == OP_ORI)  ? ALU_OR  :
                            (opcode == OP_XORI) ? ALU_XOR :
                            (opcode == OP_LUI)  ? ALU_LUI : ALU_ADD;
      end
      OP_LW, OP_LB, OP_LBU, OP_LH, OP_LHU: begin
        ctrl.alu_src_imm = 1'b1; // Address is rs plus the signed offset
        ctrl.wb_sel      = WB_LOAD;
        ctrl.reg_write   = 1'b1;
        ctrl.load_kind   = (opcode == OP_LB)  ? LD_BYTE   :
                           (opcode == OP_LBU) ? LD_BYTE_U :
                           (opcode == OP_LH)  ? LD_HALF   :
                           (opcode == OP_LHU) ? LD_HALF_U : LD_WORD;
      end
      OP_SW: begin
        ctrl.alu_src_imm = 1'b1;
        ctrl.mem_write   = 1'b1;
      end
      default: ;
    endcase
  end

endmodule

/* source/pc_unit.sv */
`include "mips_settings.svh"

module pc_unit import mips_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        clk_enable,
  input  branch_e     branch,
  input  jump_e       jump,
  input  logic        zero,
  input  logic [31:0] imm_ext,
  input  logic [25:0] jump_index,
  input  logic [31:0] jump_reg,
  output logic [31:0] pc,
  output logic [31:0] link_address,
  output logic        active
);

  logic [31:0] pc_delay;   // Fetch address for the next edge, set up one instruction early
  logic [31:0] pc_plus4;
  logic [31:0] delay_next;
  logic        branch_taken;

  assign pc_plus4     = pc + 32'd4;
  assign link_address = pc + `LINK_OFFSET; // Return lands past the delay slot

  always_comb begin
    case (branch)
      BR_BEQ:  branch_taken = zero;  // ALU subtracted rs and rt
      BR_BNE:  branch_taken = !zero;
      default: branch_taken = 1'b0;
    endcase
  end

  // The delay register skips straight to the target, so the slot instruction
  // already sitting in pc_delay still gets fetched next
  always_comb begin
    if (jump == JMP_REG) delay_next = jump_reg;
    else if (jump == JMP_IMM) delay_next = {pc_plus4[31:28], jump_index, 2'b00};
    else if (branch_taken) delay_next = pc_plus4 + {imm_ext[29:0], 2'b00};
    else delay_next = pc_delay + 32'd4;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc       <= `RESET_VECTOR;
      pc_delay <= `RESET_VECTOR + 32'd4;
      active   <= 1'b1;
    end else if (clk_enable && active) begin
      pc       <= pc_delay;
      pc_delay <= delay_next;
      if (pc_delay == `HALT_ADDRESS) active <= 1'b0; // Falls with the pc update
    end
  end

  a_pc_aligned: assert property (@(posedge clk) disable iff (!rst_n)
    active |-> pc[1:0] == 2'b00);

endmodule

/* source/regfile.sv */
`include "mips_settings.svh"

module regfile (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        write_enable,
  input  logic [4:0]  read_addr_a,
  input  logic [4:0]  read_addr_b,
  input  logic [4:0]  write_addr,
  input  logic [31:0] write_data,
  output logic [31:0] read_data_a,
  output logic [31:0] read_data_b,
  output logic [31:0] register_v0
);

  logic [31:0] regs [32];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 32; i++) regs[i] <= 32'b0;
    end else if (write_enable && write_addr != 5'd0) begin
      regs[write_addr] <= write_data; // Writes to $zero are dropped
    end
  end

  // Reads see the old value during the writing cycle
  assign read_data_a = (read_addr_a == 5'd0) ? 32'b0 : regs[read_addr_a];
  assign read_data_b = (read_addr_b == 5'd0) ? 32'b0 : regs[read_addr_b];
  assign register_v0 = regs[`V0_REG];

endmodule

/* source/alu.sv */
module alu import mips_pkg::*; (
  input  alu_op_e     op,
  input  logic [31:0] a,
  input  logic [31:0] b,
  input  logic [4:0]  shamt,
  output logic [31:0] y,
  output logic        zero
);

  logic signed [31:0] a_s;
  logic signed [31:0] b_s;

  assign a_s = a;
  assign b_s = b;

  always_comb begin
    case (op)
      ALU_ADD:  y = a + b;
      ALU_SUB:  y = a - b;  // Also the compare for beq and bne
      ALU_AND:  y = a & b;
      ALU_OR:   y = a | b;
      ALU_XOR:  y = a ^ b;
      ALU_SLT:  y = {31'b0, a_s < b_s};
      ALU_SLTU: y = {31'b0, a < b};
      // Shifts move operand B, which carries rt
      ALU_SLL:  y = b << shamt;
      ALU_SRL:  y = b >> shamt;
      ALU_SRA:  y = b_s >>> shamt;
      // Immediate goes to the upper half, the lower half clears
      ALU_LUI:  y = {b[15:0], 16'h0000};
      default:  y = 32'b0;
    endcase
  end

  assign zero = (y == 32'b0);

endmodule

/* source/load_selector.sv */
module load_selector import mips_pkg::*; (
  input  logic [31:0] word,
  input  logic [1:0]  byte_offset,
  input  load_kind_e  kind,
  output logic [31:0] y
);

  logic [7:0]  byte_sel;
  logic [15:0] half_sel;

  // Big-endian, offset 0 is the most significant byte
  always_comb begin
    case (byte_offset)
      2'd0:    byte_sel = word[31:24];
      2'd1:    byte_sel = word[23:16];
      2'd2:    byte_sel = word[15:8];
      default: byte_sel = word[7:0];
    endcase
  end

  assign half_sel = byte_offset[1] ? word[15:0] : word[31:16]; // Bit 0 ignored

  always_comb begin
    case (kind)
      LD_BYTE:   y = {{24{byte_sel[7]}}, byte_sel};
      LD_BYTE_U: y = {24'b0, byte_sel};
      LD_HALF:   y = {{16{half_sel[15]}}, half_sel};
      LD_HALF_U: y = {16'b0, half_sel};
      default:   y = word;
    endcase
  end

endmodule

/* source/datapath.sv */
`include "mips_settings.svh"

module datapath import mips_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        clk_enable,
  input  ctrl_t       ctrl,
  input  logic [31:0] instr,
  output logic        active,
  output logic [31:0] pc,
  output logic [31:0] data_address,
  output logic [31:0] data_writedata,
  output logic        data_write,
  input  logic [31:0] data_readdata,
  output logic [31:0] register_v0
);

  logic [31:0] rda;
  logic [31:0] rdb;
  logic [31:0] imm_ext;
  logic [31:0] alu_b;
  logic [31:0] alu_y;
  logic [31:0] load_data;
  logic [31:0] link_address;
  logic [31:0] wb_data;
  logic [4:0]  wb_reg;
  logic [4:0]  shamt;
  logic        zero;
  logic        commit;    // This cycle's instruction takes effect on the coming edge

  assign commit = clk_enable && active;

  assign imm_ext = ctrl.imm_zero_ext ? {16'b0, instr[15:0]}
                                     : {{16{instr[15]}}, instr[15:0]};
  assign alu_b   = ctrl.alu_src_imm ? imm_ext : rdb;
  assign shamt   = ctrl.shift_by_shamt ? instr[10:6] : 5'd0;

  always_comb begin
    case (ctrl.reg_dst)
      DST_RD:   wb_reg = instr[15:11];
      DST_LINK: wb_reg = `LINK_REG;
      default:  wb_reg = instr[20:16];
    endcase
  end

  always_comb begin
    case (ctrl.wb_sel)
      WB_LOAD: wb_data = load_data;
      WB_LINK: wb_data = link_address; // jal and jalr return address
      default: wb_data = alu_y;
    endcase
  end

  pc_unit i_pc_unit (
    .clk          (clk),
    .rst_n        (rst_n),
    .clk_enable   (clk_enable),
    .branch       (ctrl.branch),
    .jump         (ctrl.jump),
    .zero         (zero),
    .imm_ext      (imm_ext),
    .jump_index   (instr[25:0]),
    .jump_reg     (rda),         // jr and jalr target straight from rs
    .pc           (pc),
    .link_address (link_address),
    .active       (active)
  );

  regfile i_regfile (
    .clk          (clk),
    .rst_n        (rst_n),
    .write_enable (ctrl.reg_write && commit),
    .read_addr_a  (instr[25:21]),
    .read_addr_b  (instr[20:16]),
    .write_addr   (wb_reg),
    .write_data   (wb_data),
    .read_data_a  (rda),
    .read_data_b  (rdb),
    .register_v0  (register_v0)
  );

  alu i_alu (.op(ctrl.alu_op), .a(rda), .b(alu_b), .shamt(shamt), .y(alu_y), .zero(zero));

  load_selector i_load_selector (
    .word        (data_readdata),
    .byte_offset (alu_y[1:0]),
    .kind        (ctrl.load_kind),
    .y           (load_data)
  );

  // Memory sees the ALU sum as the address and rt as store data
  assign data_address   = alu_y;
  assign data_writedata = rdb;
  assign data_write     = ctrl.mem_write && commit;

endmodule

/* source/mips_cpu.sv */
module mips_cpu import mips_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        clk_enable,
  output logic        active,
  output logic [31:0] instr_address,
  input  logic [31:0] instr_readdata,
  output logic [31:0] data_address,
  output logic [31:0] data_writedata,
  output logic        data_write,
  input  logic [31:0] data_readdata,
  output logic [31:0] register_v0
);

  ctrl_t ctrl; // Decoded from the word fetched this cycle

  control_decoder i_control_decoder (.instr(instr_readdata), .ctrl(ctrl));

  datapath i_datapath (
    .clk            (clk),
    .rst_n          (rst_n),
    .clk_enable     (clk_enable),
    .ctrl           (ctrl),
    .instr          (instr_readdata),
    .active         (active),
    .pc             (instr_address),
    .data_address   (data_address),
    .data_writedata (data_writedata),
    .data_write     (data_write),
    .data_readdata  (data_readdata),
    .register_v0    (register_v0)
  );

endmodule

/* test/tb_mips_cpu.sv */
`include "mips_settings.svh"

module tb_mips_cpu import mips_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  typedef struct packed {
    logic [31:0] fetch;    // Address that should be on instr_address this cycle
    logic [31:0] st_addr;
    logic [31:0] st_data;
    logic        st;
  } step_t;

  logic        clk;
  logic        rst_n;
  logic        clk_enable;
  logic        active;
  logic [31:0] instr_address;
  logic [31:0] instr_readdata;
  logic [31:0] data_address;
  logic [31:0] data_writedata;
  logic        data_write;
  logic [31:0] data_readdata;
  logic [31:0] register_v0;

  logic [31:0] imem [int];   // Program, shared by DUT and model
  logic [31:0] dmem [int];   // Written only by the DUT
  logic [31:0] mdmem [int];  // Model copy of data memory
  logic [31:0] mregs [32];
  logic [31:0] mpc;
  logic [31:0] mnpc;
  logic        mactive;
  logic [31:0] here;         // Next free program address
  logic        running;
  step_t       res;

  funct_e r_ops [10] = '{FN_ADDU, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_SLT, FN_SLTU,
                         FN_SLL, FN_SRL, FN_SRA};
  opcode_e i_ops [6] = '{OP_ADDIU, OP_ANDI, OP_ORI, OP_XORI, OP_SLTI, OP_LUI};

  mips_cpu i_mips_cpu (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Memories are windowed, only the low address bits pick the word
  function automatic int word_index(logic [31:0] a);
    return {18'b0, a[15:2]};
  endfunction

  function automatic logic [31:0] mem_fill(logic [31:0] a);
    return {a[15:0], a[31:16]} ^ 32'h3c3cc3c3;
  endfunction

  always_comb begin
    instr_readdata = imem.exists(word_index(instr_address)) ? imem[word_index(instr_address)]
                                                            : 32'h0; // Empty slots are nops
    data_readdata  = dmem.exists(word_index(data_address)) ? dmem[word_index(data_address)]
                                                           : mem_fill(data_address);
  end

  always @(posedge clk) begin
    if (data_write) dmem[word_index(data_address)] = data_writedata;
  end

  function automatic logic [31:0] enc_r(funct_e fn, logic [4:0] rs, logic [4:0] rt,
                                        logic [4:0] rd, logic [4:0] sh);
    return {6'h00, rs, rt, rd, sh, fn};
  endfunction

  function automatic logic [31:0] enc_i(opcode_e op, logic [4:0] rs, logic [4:0] rt,
                                        logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic logic [31:0] enc_j(opcode_e op, logic [31:0] target);
    return {op, target[27:2]}; // Upper region comes from the delay slot address
  endfunction

  task automatic emit(input logic [31:0] w);
    imem[word_index(here)] = w;
    here = here + 32'd4;
  endtask

  task automatic load_const(input logic [4:0] r, input logic [31:0] v);
    emit(enc_i(OP_LUI, 5'd0, r, v[31:16]));
    emit(enc_i(OP_ORI, r, r, v[15:0]));
  endtask

  function automatic logic [31:0] read_mdmem(logic [31:0] a);
    return mdmem.exists(word_index(a)) ? mdmem[word_index(a)] : mem_fill(a);
  endfunction

  // Reference ISA model, one instruction per call with the delay slot kept in mnpc
  function automatic step_t step_model();
    logic [31:0] ins;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_s;
    logic [31:0] imm_z;
    logic [31:0] val;
    logic [31:0] addr;
    logic [31:0] w;
    logic [31:0] pc_plus4;
    logic [31:0] next_npc;
    logic [4:0]  dst;
    logic        wr;
    opcode_e     op;
    funct_e      fn;
    step_t       r;
    ins      = imem.exists(word_index(mpc)) ? imem[word_index(mpc)] : 32'h0;
    op       = opcode_e'(ins[31:26]);
    fn       = funct_e'(ins[5:0]);
    a        = mregs[ins[25:21]];
    b        = mregs[ins[20:16]];
    imm_s    = {{16{ins[15]}}, ins[15:0]};
    imm_z    = {16'b0, ins[15:0]};
    addr     = a + imm_s;
    pc_plus4 = mpc + 32'd4; // Address of the delay slot
    r        = '{fetch: mpc, st_addr: 32'h0, st_data: 32'h0, st: 1'b0};
    next_npc = mnpc + 32'd4;
    dst      = ins[20:16]; // I-type writes rt
    wr       = 1'b1;
    val      = 32'h0;
    case (op)
      OP_RTYPE: begin
        dst = ins[15:11];
        case (fn)
          FN_ADDU: val = a + b;
          FN_SUBU: val = a - b;
          FN_AND:  val = a & b;
          FN_OR:   val = a | b;
          FN_XOR:  val = a ^ b;
          FN_SLT:  val = {31'b0, $signed(a) < $signed(b)};
          FN_SLTU: val = {31'b0, a < b};
          FN_SLL:  val = b << ins[10:6];
          FN_SRL:  val = b >> ins[10:6];
          FN_SRA:  val = $signed(b) >>> ins[10:6];
          FN_JR: begin
            next_npc = a;
            wr       = 1'b0;
          end
          FN_JALR: begin
            next_npc = a;
            val      = mpc + 32'd8;
          end
          default: wr = 1'b0;
        endcase
      end
      OP_J: begin
        next_npc = {pc_plus4[31:28], ins[25:0], 2'b00};
        wr       = 1'b0;
      end
      OP_JAL: begin
        next_npc = {pc_plus4[31:28], ins[25:0], 2'b00};
        dst      = 5'd31;
        val      = mpc + 32'd8;
      end
      OP_BEQ: begin
        if (a == b) next_npc = pc_plus4 + (imm_s << 2);
        wr = 1'b0;
      end
      OP_BNE: begin
        if (a != b) next_npc = pc_plus4 + (imm_s << 2);
        wr = 1'b0;
      end
      OP_ADDIU: val = a + imm_s;
      OP_SLTI:  val = {31'b0, $signed(a) < $signed(imm_s)};
      OP_ANDI:  val = a & imm_z;
      OP_ORI:   val = a | imm_z;
      OP_XORI:  val = a ^ imm_z;
      OP_LUI:   val = {ins[15:0], 16'h0};
      OP_LW, OP_LB, OP_LBU, OP_LH, OP_LHU: begin
        // Big-endian, so offset 0 sits at the top of the word
        w = read_mdmem(addr);
        if (op == OP_LB || op == OP_LBU) w = w >> (24 - 8 * int'(addr[1:0]));
        if (op == OP_LH || op == OP_LHU) w = w >> (16 - 16 * int'(addr[1]));
        case (op)
          OP_LB:   val = {{24{w[7]}}, w[7:0]};
          OP_LBU:  val = {24'b0, w[7:0]};
          OP_LH:   val = {{16{w[15]}}, w[15:0]};
          OP_LHU:  val = {16'b0, w[15:0]};
          default: val = w;
        endcase
      end
      OP_SW: begin
        r.st = 1'b1;
        r.st_addr = addr;
        r.st_data = b;
        mdmem[word_index(addr)] = b;
        wr = 1'b0;
      end
      default: wr = 1'b0;
    endcase
    if (wr && dst != 5'd0) mregs[dst] = val;
    mpc  = mnpc;
    mnpc = next_npc;
    if (mpc == `HALT_ADDRESS) mactive = 1'b0;
    return r;
  endfunction

  task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, exp);
      $display("STATUS: FAIL");
      $fatal(1, "check failed");
    end
  endtask

  task automatic build_program();
    logic [31:0] p;
    logic [31:0] v;
    logic [4:0]  rd;
    for (int i = 8; i < 16; i++) load_const(5'(i), $urandom);
    // Straight-line ALU mix into r16 to r23
    for (int i = 0; i < 16; i++) begin
      rd = 5'(16 + i % 8);
      if ($urandom % 2 == 0)
        emit(enc_r(r_ops[$urandom % 10], 5'(8 + $urandom % 8), 5'(8 + $urandom % 8), rd,
                   5'($urandom % 32)));
      else
        emit(enc_i(i_ops[$urandom % 6], 5'(8 + $urandom % 8), rd, 16'($urandom)));
    end
    for (int i = 0; i < 8; i++) emit(enc_i(OP_SW, 5'd0, 5'(16 + i), 16'(32'h100 + 4 * i)));
    // Four random words to load from, in both memories
    for (int i = 0; i < 4; i++) begin
      v = $urandom;
      dmem[word_index(32'h400 + 4 * i)]  = v;
      mdmem[word_index(32'h400 + 4 * i)] = v;
    end
    for (int i = 0; i < 16; i++) begin
      emit(enc_i(OP_LB,  5'd0, 5'd24, 16'(32'h400 + i)));
      emit(enc_i(OP_SW,  5'd0, 5'd24, 16'(32'h800 + 16 * i)));
      emit(enc_i(OP_LBU, 5'd0, 5'd24, 16'(32'h400 + i)));
      emit(enc_i(OP_SW,  5'd0, 5'd24, 16'(32'h804 + 16 * i)));
      emit(enc_i(i % 2 == 0 ? OP_LH : OP_LHU, 5'd0, 5'd24, 16'(32'h400 + (i & ~1))));
      emit(enc_i(OP_SW,  5'd0, 5'd24, 16'(32'h808 + 16 * i)));
      emit(enc_i(OP_LW,  5'd0, 5'd24, 16'(32'h400 + (i & ~3))));
      emit(enc_i(OP_SW,  5'd0, 5'd24, 16'(32'h80C + 16 * i)));
    end
    // Branches: each is followed by its slot and one filler that a taken branch skips
    emit(enc_i(OP_BEQ, 5'd8, 5'd8, 16'd2));
    emit(enc_i(OP_ADDIU, 5'd25, 5'd25, 16'd1));
    emit(enc_i(OP_ADDIU, 5'd25, 5'd25, 16'd100));
    emit(enc_i(OP_BNE, 5'd8, 5'd8, 16'd2));
    emit(enc_i(OP_ADDIU, 5'd25, 5'd25, 16'd2));
    emit(enc_i(OP_ADDIU, 5'd25, 5'd25, 16'd200));
    emit(enc_i(OP_BNE, 5'd8, 5'd0, 16'd2));
    emit(enc_i(OP_ADDIU, 5'd25, 5'd25, 16'd3));
    emit(enc_i(OP_ADDIU, 5'd25, 5'd25, 16'd300));
    emit(enc_i(OP_BEQ, 5'd8, 5'd0, 16'd2));
    emit(enc_i(OP_ADDIU, 5'd25, 5'd25, 16'd4));
    emit(enc_i(OP_ADDIU, 5'd25, 5'd25, 16'd400));
    // jal to a subroutine that returns with jr, then j past it
    p = here;
    emit(enc_j(OP_JAL, p + 32'd16));
    emit(enc_i(OP_ADDIU, 5'd25, 5'd25, 16'd5));
    emit(enc_j(OP_J, p + 32'd24));
    emit(enc_i(OP_ADDIU, 5'd25, 5'd25, 16'd6));
    emit(enc_r(FN_JR, 5'd31, 5'd0, 5'd0, 5'd0));
    emit(enc_i(OP_ADDIU, 5'd25, 5'd25, 16'd7));
    p = here;
    load_const(5'd29, p + 32'd20);
    emit(enc_r(FN_JALR, 5'd29, 5'd0, 5'd30, 5'd0));
    emit(enc_i(OP_ADDIU, 5'd25, 5'd25, 16'd8));
    emit(enc_i(OP_ADDIU, 5'd25, 5'd25, 16'd800));
    emit(enc_i(OP_SW, 5'd0, 5'd25, 16'h0C00));
    emit(enc_i(OP_SW, 5'd0, 5'd31, 16'h0C04));
    emit(enc_i(OP_SW, 5'd0, 5'd30, 16'h0C08));
    emit(enc_r(FN_ADDU, 5'd25, 5'd16, 5'd2, 5'd0));
    emit(enc_r(FN_JR, 5'd0, 5'd0, 5'd0, 5'd0)); // Halt through jr $0
    emit(enc_i(OP_ADDIU, 5'd2, 5'd2, 16'd1));    // Slot still runs
  endtask

  // Random stretches with the clock enable low
  task automatic stall_clk_enable();
    forever begin
      repeat (1 + $urandom % 8) @(posedge clk);
      #1 clk_enable = 1'b0;
      repeat (1 + $urandom % 4) @(posedge clk);
      #1 clk_enable = 1'b1;
    end
  endtask

  always @(negedge clk) begin
    if (running) begin
      check("active", {31'b0, active}, {31'b0, mactive});
      if (!mactive || !clk_enable) begin
        check("instr_address while held", instr_address, mpc);
        check("data_write while held", {31'b0, data_write}, 32'h0);
      end else begin
        res = step_model();
        check("instr_address", instr_address, res.fetch);
        check("data_write", {31'b0, data_write}, {31'b0, res.st});
        if (res.st) begin
          check("store address", data_address, res.st_addr);
          check("store data", data_writedata, res.st_data);
        end
      end
    end
  end

  task automatic wait_for_halt(input int limit);
    int n;
    n = 0;
    while (mactive || active) begin
      @(negedge clk);
      n++;
      if (n > limit) begin
        $display("ERROR: the core did not halt within %0d cycles", limit);
        $display("STATUS: FAIL");
        $fatal(1, "timeout");
      end
    end
  endtask

  initial begin
    void'($urandom(32'h8a894288));
    rst_n      = 1'b0;
    clk_enable = 1'b0;
    running    = 1'b0;
    here       = `RESET_VECTOR;
    mpc        = `RESET_VECTOR;
    mnpc       = `RESET_VECTOR + 32'd4;
    mactive    = 1'b1;
    for (int i = 0; i < 32; i++) mregs[i] = 32'h0;
    build_program();
    repeat (3) @(posedge clk);
    #1 rst_n = 1'b1;
    @(negedge clk);
    check("instr_address after reset", instr_address, `RESET_VECTOR);
    check("active after reset", {31'b0, active}, 32'h1);
    check("data_write after reset", {31'b0, data_write}, 32'h0);
    running = 1'b1;
    @(posedge clk);
    #1 clk_enable = 1'b1;
    fork
      stall_clk_enable();
    join_none
    wait_for_halt(4000);
    check("register_v0 at halt", register_v0, mregs[`V0_REG]);
    // Once halted, the fetch address and v0 must stay where the model left them
    repeat (10) begin
      @(negedge clk);
      check("instr_address after halt", instr_address, `HALT_ADDRESS);
      check("register_v0 after halt", register_v0, mregs[`V0_REG]);
    end
    $display("STATUS: PASS");
    $finish;
  end

endmodule

/* tb.f */
+incdir+source
source/mips_pkg.sv
source/control_decoder.sv
source/pc_unit.sv
source/regfile.sv
source/alu.sv
source/load_selector.sv
source/datapath.sv
source/mips_cpu.sv
test/tb_mips_cpu.sv

/* run_sim.sh */
#!/bin/bash
# Build and run the testbench with Verilator, pass only if the log holds the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module tb_mips_cpu -o sim_mips \
  && ./obj_dir/sim_mips > sim.log 2>&1

grep -q "STATUS: PASS" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed, see sim.log"; exit 1; }
